// ==== filelist.f ====
logic/video_pkg.sv
logic/sprite_pkg.sv
logic/sprite_ram.sv
logic/sprite_ctrl.sv
logic/sprite_fill.sv
logic/line_store.sv
logic/sprites.sv
sim/sprites_chk.sv
sim/sprites_tb.sv

// ==== run.sh ====
#!/bin/sh
# Verilator build and run of the sprite renderer testbench

cd "$(dirname "$0")" || exit 1

rm -rf obj_dir
verilator --binary --timing --assert -f filelist.f --top-module sprites_tb \
	-o sim_sprites > build.log 2>&1
if [ $? -ne 0 ]; then
	cat build.log
	echo "verilator build failed"
	exit 1
fi

# keep running past assertion errors so the testbench reports the counts
./obj_dir/sim_sprites +verilator+error+limit+1000 > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -q "^sim passed$" sim.log; then
	exit 0
fi
exit 1

// ==== sim/sprites_tb.sv ====
module sprites_tb
	import video_pkg::*;
	import sprite_pkg::*;
();

	localparam int H_PIXELS = 64;
	localparam int V_LINES = 16;
	localparam int N_SPRITES = 8;
	localparam int N_TESTS = 6;
	localparam int LINES_PER_TEST = 40;
	// all tests at the slow pixel rate in time units
	localparam int WATCHDOG = N_TESTS * LINES_PER_TEST * H_PIXELS * 6 * 10;

	logic clk;
	logic line_start;
	logic spr_en;
	logic cend = 1'b0;
	logic desc_we;
	logic [SIDX_W-1:0] desc_idx;
	sprite_desc_t desc_wdata;
	spx_t pix;
	logic overrun;

	int cend_period = 6;
	int cdiv = 0;
	int cend_count;
	int test_no = 0;
	int tests_failed = 0;
	int fails_before = 0;
	logic [31:0] rng = 32'h0b52_85c2;

	sprites #(
		.H_PIXELS(H_PIXELS),
		.V_LINES(V_LINES),
		.N_SPRITES(N_SPRITES)
	) dut0 (
		.clk(clk),
		.line_start(line_start),
		.spr_en(spr_en),
		.cend(cend),
		.desc_we(desc_we),
		.desc_idx(desc_idx),
		.desc_wdata(desc_wdata),
		.pix(pix),
		.overrun(overrun)
	);

	initial
	begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	// pixel strobe of one clock every cend_period clocks
	always @(negedge clk)
	begin
		if (cdiv >= cend_period - 1)
		begin
			cdiv <= 0;
			cend <= 1'b1;
		end
		else
		begin
			cdiv <= cdiv + 1;
			cend <= 1'b0;
		end
	end

	always @(posedge clk or posedge line_start)
	begin
		if (line_start)
			cend_count <= 0;
		else if (cend)
			cend_count <= cend_count + 1;
	end

	initial
	begin
		#(WATCHDOG);
		$display("watchdog expired, the tests did not finish in time");
		$display("sim failed");
		$finish;
	end

	function automatic logic [31:0] xorshift(logic [31:0] s);
		logic [31:0] r;
		r = s ^ (s << 13);
		r = r ^ (r >> 17);
		r = r ^ (r << 5);
		return r;
	endfunction

	task automatic rand_desc(output sprite_desc_t d, input int max_x);
		rng = xorshift(rng);
		d.x = HADR_W'(rng % max_x);
		rng = xorshift(rng);
		d.y = VADR_W'(rng[3:0]);
		d.height = HEIGHT_W'(1 + rng[6:4]);
		d.width = WIDTH_W'(1 + rng[15:8] % 31);
		d.color = PIX_W'(1 + rng[27:20] % 63);
	endtask

	task automatic apply_reset();
		@(negedge clk);
		line_start = 1'b1;
		repeat (8) @(negedge clk);
		line_start = 1'b0;
	endtask

	task automatic write_desc(input int idx, input sprite_desc_t d);
		@(negedge clk);
		desc_we = 1'b1;
		desc_idx = SIDX_W'(idx);
		desc_wdata = d;
		@(negedge clk);
		desc_we = 1'b0;
	endtask

	task automatic clear_table();
		for (int i = 0; i < N_SPRITES; i++)
			write_desc(i, '0);
	endtask

	// runs to the end of the n-th line from here
	task automatic run_lines(input int n);
		int target;
		target = (cend_count / H_PIXELS + n) * H_PIXELS;
		while (cend_count < target)
			@(negedge clk);
	endtask

	task automatic wait_pixels(input int n);
		int target;
		target = cend_count + n;
		while (cend_count < target)
			@(negedge clk);
	endtask

	task automatic report_test(input string name);
		int errs;
		test_no++;
		errs = dut0.chk0.fails - fails_before;
		fails_before = dut0.chk0.fails;
		if (errs != 0)
			tests_failed++;
		$display("test %0d %s: %0d assertion failures", test_no, name, errs);
	endtask

	initial
	begin
		sprite_desc_t d;
		line_start = 1'b1;
		spr_en = 1'b1;
		desc_we = 1'b0;
		desc_idx = '0;
		desc_wdata = '0;

		apply_reset();
		clear_table();
		rand_desc(d, 40);
		write_desc(3, d);
		run_lines(2 * V_LINES);
		report_test("single sprite");

		apply_reset();
		clear_table();
		rand_desc(d, 30);
		// wide and tall enough that all three overlap
		d.y = d.y >> 1;
		d.height = 6'd6;
		d.width = 5'd16;
		write_desc(2, d);
		d.x = d.x + 9'd4;
		d.y = d.y + 9'd1;
		d.color = d.color ^ 6'h15;
		write_desc(5, d);
		d.x = d.x + 9'd4;
		d.color = d.color ^ 6'h2a;
		write_desc(7, d);
		run_lines(2 * V_LINES);
		report_test("overlap");

		apply_reset();
		clear_table();
		rand_desc(d, 20);
		write_desc(0, d);
		rand_desc(d, 64);
		d.x = HADR_W'(50 + rng % 10);
		d.width = WIDTH_W'(20 + rng[19:16] % 12);
		write_desc(1, d);
		// starts beyond the last pixel
		rand_desc(d, 64);
		d.x = 9'd70;
		write_desc(6, d);
		run_lines(2 * V_LINES);
		report_test("clipping");

		apply_reset();
		clear_table();
		for (int i = 0; i < 4; i++)
		begin
			rand_desc(d, 60);
			write_desc(i, d);
		end
		run_lines(4);
		spr_en = 1'b0;
		run_lines(6);
		spr_en = 1'b1;
		run_lines(6);
		report_test("enable");

		apply_reset();
		clear_table();
		for (int i = 0; i < 2; i++)
		begin
			rand_desc(d, 40);
			d.width = 5'd4;
			write_desc(i, d);
		end
		run_lines(4);
		spr_en = 1'b0;
		for (int i = 0; i < N_SPRITES; i++)
		begin
			d.x = HADR_W'(i * 4);
			d.y = '0;
			d.height = 6'd16;
			d.width = 5'd31;
			d.color = PIX_W'(i + 1);
			write_desc(i, d);
		end
		// eight wide sprites no longer fit in the shorter line
		cend_period = 3;
		spr_en = 1'b1;
		run_lines(6);
		cend_period = 6;
		report_test("overrun");

		apply_reset();
		clear_table();
		rand_desc(d, 40);
		write_desc(1, d);
		rand_desc(d, 40);
		write_desc(4, d);
		rand_desc(d, 40);
		write_desc(6, d);
		run_lines(4);
		wait_pixels(30);
		rand_desc(d, 40);
		write_desc(4, d);
		run_lines(6);
		report_test("descriptor update");

		$display("%0d tests run, %0d failed, %0d assertion failures",
			test_no, tests_failed, dut0.chk0.fails);
		if (tests_failed == 0 && dut0.chk0.fails == 0)
			$display("sim passed");
		else
			$display("sim failed");
		$finish;
	end

endmodule

// ==== sim/sprites_chk.sv ====
module sprites_chk
	import video_pkg::*;
	import sprite_pkg::*;
#(
	parameter int H_PIXELS = 360,
	parameter int V_LINES = 288,
	parameter int N_SPRITES = 8
)
(
	input logic clk,
	input logic line_start,
	input logic spr_en,
	input logic cend,
	input logic desc_we,
	input logic [SIDX_W-1:0] desc_idx,
	input sprite_desc_t desc_wdata,
	input spx_t pix,
	input logic overrun
);

	localparam int H_LAST = H_PIXELS - 1;

	int fails = 0;

	// host view of the table with snapshots at fill start and on display
	sprite_desc_t shadow [8];
	sprite_desc_t fill_tbl [8];
	sprite_desc_t disp_tbl [8];

	int hcnt;
	int vcnt;
	int vnext;
	int fline;
	int lines_seen;
	int cyc;
	int fill_cost;
	logic line_end;
	logic fill_on;
	logic fill_amb;
	logic disp_on;
	logic disp_ok;
	logic exp_over;
	logic v1;
	logic v2;
	logic c1;
	spx_t e1;
	spx_t e2;

	function automatic logic on_line(sprite_desc_t d, int line);
		int ys;
		int hs;
		ys = int'(d.y);
		hs = int'(d.height);
		return (d.width != '0) && (int'(d.x) <= H_LAST) &&
			(line >= ys) && (line < ys + hs);
	endfunction

	// last pixel drawn after clipping
	function automatic int right_edge(sprite_desc_t d);
		int r;
		r = int'(d.x) + int'(d.width) - 1;
		if (r > H_LAST)
			r = H_LAST;
		return r;
	endfunction

	function automatic spx_t expect_pix(int line, int h);
		spx_t p;
		p = '0;
		for (int i = 0; i < N_SPRITES; i++)
		begin
			if (on_line(disp_tbl[i], line) && h >= int'(disp_tbl[i].x) &&
				h <= right_edge(disp_tbl[i]))
			begin
				p.en = 1'b1;
				p.pixel = disp_tbl[i].color;
			end
		end
		return p;
	endfunction

	// two clocks per descriptor plus one per pixel written
	function automatic int fill_cycles(int line);
		int c;
		c = 0;
		for (int i = 0; i < N_SPRITES; i++)
		begin
			c = c + 2;
			if (on_line(shadow[i], line))
				c = c + right_edge(shadow[i]) - int'(shadow[i].x) + 1;
		end
		return c;
	endfunction

	assign line_end = cend && (hcnt == H_LAST);
	assign vnext = (vcnt == V_LINES - 1) ? 0 : vcnt + 1;
	assign fline = (vnext == V_LINES - 1) ? 0 : vnext + 1;

	always_ff @(posedge clk or posedge line_start)
	begin
		if (line_start)
		begin
			hcnt <= 0;
			vcnt <= 0;
			lines_seen <= 0;
			cyc <= 0;
			fill_on <= 1'b0;
			fill_amb <= 1'b0;
			disp_on <= 1'b0;
			disp_ok <= 1'b0;
			exp_over <= 1'b0;
			v1 <= 1'b0;
			v2 <= 1'b0;
		end
		else
		begin
			cyc <= cyc + 1;
			if (desc_we)
			begin
				shadow[desc_idx] <= desc_wdata;
				fill_amb <= 1'b1;
			end
			if (line_end)
			begin
				hcnt <= 0;
				vcnt <= vnext;
				cyc <= 0;
				lines_seen <= lines_seen + 1;
				// fill still running when the line ends
				if (fill_on && fill_cost > cyc)
					exp_over <= 1'b1;
				disp_ok <= (lines_seen >= 1) && !fill_amb && !(fill_on && fill_cost > cyc);
				disp_on <= fill_on;
				disp_tbl <= fill_tbl;
				fill_tbl <= shadow;
				fill_on <= spr_en;
				fill_cost <= fill_cycles(fline);
				fill_amb <= desc_we;
			end
			else if (cend)
				hcnt <= hcnt + 1;

			// pix follows cend by two clocks
			v1 <= cend;
			c1 <= disp_ok;
			e1 <= disp_on ? expect_pix(vcnt, hcnt) : '0;
			v2 <= v1 && (c1 || !spr_en);
			e2 <= '{en: e1.en && spr_en, pixel: e1.pixel};
		end
	end

	pix_value: assert property (@(posedge clk) disable iff (line_start)
		v2 |-> (pix.en == e2.en) && (!e2.en || pix.pixel == e2.pixel))
	else
	begin
		$error("Mismatch at %0t: pix expected en %0b colour %0d, got en %0b colour %0d",
			$time, e2.en, e2.pixel, $sampled(pix.en), $sampled(pix.pixel));
		fails = fails + 1;
	end

	overrun_value: assert property (@(posedge clk) disable iff (line_start)
		overrun == exp_over)
	else
	begin
		$error("Mismatch at %0t: overrun expected %0b, got %0b",
			$time, exp_over, $sampled(overrun));
		fails = fails + 1;
	end

	// blanking follows spr_en within one clock
	disabled_dark: assert property (@(posedge clk) disable iff (line_start)
		!spr_en |=> !pix.en)
	else
	begin
		$error("pix.en still high at %0t while spr_en is low", $time);
		fails = fails + 1;
	end

endmodule

bind sprites sprites_chk #(
	.H_PIXELS(H_PIXELS),
	.V_LINES(V_LINES),
	.N_SPRITES(N_SPRITES)
) chk0 (
	.clk(clk),
	.line_start(line_start),
	.spr_en(spr_en),
	.cend(cend),
	.desc_we(desc_we),
	.desc_idx(desc_idx),
	.desc_wdata(desc_wdata),
	.pix(pix),
	.overrun(overrun)
);

// ==== logic/sprites.sv ====
module sprites
	import video_pkg::*;
	import sprite_pkg::*;
#(
	parameter int H_PIXELS = 360,
	parameter int V_LINES = 288,
	parameter int N_SPRITES = 8
)
(
	input logic clk,
	input logic line_start,
	input logic spr_en,
	input logic cend,
	input logic desc_we,
	input logic [SIDX_W-1:0] desc_idx,
	input sprite_desc_t desc_wdata,
	output spx_t pix,
	output logic overrun
);

	// sequencer to span drawer
	logic span_go;
	logic [HADR_W-1:0] span_x;
	logic [WIDTH_W-1:0] span_w;
	logic [PIX_W-1:0] span_color;
	logic span_done;

	// raster side of the line buffers
	logic [HADR_W-1:0] hcount;
	logic rd_stb;
	logic l_sel;

	// fill side of the line buffers
	logic wr_stb;
	logic [HADR_W-1:0] wr_adr;
	spx_t wr_pix;

	sprite_ctrl #(
		.H_PIXELS(H_PIXELS),
		.V_LINES(V_LINES),
		.N_SPRITES(N_SPRITES)
	) u_ctrl (
		.clk(clk),
		.line_start(line_start),
		.spr_en(spr_en),
		.cend(cend),
		.desc_we(desc_we),
		.desc_idx(desc_idx),
		.desc_wdata(desc_wdata),
		.span_go(span_go),
		.span_x(span_x),
		.span_w(span_w),
		.span_color(span_color),
		.span_done(span_done),
		.hcount(hcount),
		.rd_stb(rd_stb),
		.l_sel(l_sel),
		.overrun(overrun)
	);

	sprite_fill #(
		.H_PIXELS(H_PIXELS)
	) u_fill (
		.clk(clk),
		.line_start(line_start),
		.span_go(span_go),
		.span_x(span_x),
		.span_w(span_w),
		.span_color(span_color),
		.span_done(span_done),
		.wr_stb(wr_stb),
		.wr_adr(wr_adr),
		.wr_pix(wr_pix)
	);

	line_store u_store (
		.clk(clk),
		.line_start(line_start),
		.l_sel(l_sel),
		.spr_en(spr_en),
		.hcount(hcount),
		.rd_stb(rd_stb),
		.wr_stb(wr_stb),
		.wr_adr(wr_adr),
		.wr_pix(wr_pix),
		.pix(pix)
	);

endmodule

// ==== logic/line_store.sv ====
module line_store
	import video_pkg::*;
(
	input logic clk,
	input logic line_start,
	input logic l_sel,
	input logic spr_en,
	input logic [HADR_W-1:0] hcount,
	input logic rd_stb,
	input logic wr_stb,
	input logic [HADR_W-1:0] wr_adr,
	input spx_t wr_pix,
	output spx_t pix
);

	localparam int DEPTH = 2 ** HADR_W;

	logic rd_q;
	logic sel_q;
	logic [HADR_W-1:0] clr_adr;
	spx_t rdat [2];
	spx_t front;

	// buffer l_sel is on display, the other one is being filled
	for (genvar b = 0; b < 2; b++)
	begin : g_buf
		logic clr;
		logic fill;

		// clear uses the select seen at the read, it may have flipped since
		assign clr = rd_q && (sel_q == 1'(b));
		assign fill = wr_stb && (l_sel != 1'(b));

		sprite_ram #(
			.DEPTH(DEPTH),
			.payload_t(spx_t)
		) u_ram (
			.clk(clk),
			.w_stb(clr || fill),
			.w_adr(clr ? clr_adr : wr_adr),
			.w_dat(clr ? spx_t'('0) : wr_pix),
			.r_adr(hcount),
			.r_dat(rdat[b])
		);
	end

	assign front = sel_q ? rdat[1] : rdat[0];

	always_ff @(posedge clk)
	begin
		if (rd_stb)
			clr_adr <= hcount;
	end

	// read data lands one clock after rd_stb, pix one clock later
	always_ff @(posedge clk or posedge line_start)
	begin
		if (line_start)
		begin
			rd_q <= 1'b0;
			sel_q <= 1'b0;
			pix <= '0;
		end
		else
		begin
			rd_q <= rd_stb;
			if (rd_stb)
				sel_q <= l_sel;
			if (rd_q)
				pix <= '{en: front.en && spr_en, pixel: front.pixel};
			else if (!spr_en)
				pix.en <= 1'b0;
		end
	end

endmodule

// ==== logic/sprite_fill.sv ====
module sprite_fill
	import video_pkg::*;
	import sprite_pkg::*;
#(
	parameter int H_PIXELS = 360
)
(
	input logic clk,
	input logic line_start,
	input logic span_go,
	input logic [HADR_W-1:0] span_x,
	input logic [WIDTH_W-1:0] span_w,
	input logic [PIX_W-1:0] span_color,
	output logic span_done,
	output logic wr_stb,
	output logic [HADR_W-1:0] wr_adr,
	output spx_t wr_pix
);

	// one extra bit so x + width cannot wrap
	localparam int EXT_W = HADR_W + 1;
	localparam logic [EXT_W-1:0] H_LAST = EXT_W'(H_PIXELS - 1);

	logic busy;
	logic [HADR_W-1:0] adr;
	logic [HADR_W-1:0] last_adr;
	logic [PIX_W-1:0] color;
	logic [EXT_W-1:0] span_end;

	// rightmost pixel before clipping
	assign span_end = {1'b0, span_x} + EXT_W'(span_w) - 1'b1;

	always_ff @(posedge clk or posedge line_start)
	begin
		if (line_start)
			busy <= 1'b0;
		else if (span_go)
			busy <= (span_w != '0);
		else if (span_done)
			busy <= 1'b0;
	end

	always_ff @(posedge clk)
	begin
		if (span_go)
		begin
			adr <= span_x;
			color <= span_color;
			// clip at the right edge
			if (span_end > H_LAST)
				last_adr <= H_LAST[HADR_W-1:0];
			else
				last_adr <= span_end[HADR_W-1:0];
		end
		else if (busy)
			adr <= adr + 1'b1;
	end

	// one opaque pixel per busy cycle
	assign span_done = busy && (adr == last_adr);
	assign wr_stb = busy;
	assign wr_adr = adr;
	assign wr_pix = '{en: 1'b1, pixel: color};

endmodule

// ==== logic/sprite_ctrl.sv ====
module sprite_ctrl
	import video_pkg::*;
	import sprite_pkg::*;
#(
	parameter int H_PIXELS = 360,
	parameter int V_LINES = 288,
	parameter int N_SPRITES = 8
)
(
	input logic clk,
	input logic line_start,
	input logic spr_en,
	input logic cend,
	input logic desc_we,
	input logic [SIDX_W-1:0] desc_idx,
	input sprite_desc_t desc_wdata,
	output logic span_go,
	output logic [HADR_W-1:0] span_x,
	output logic [WIDTH_W-1:0] span_w,
	output logic [PIX_W-1:0] span_color,
	input logic span_done,
	output logic [HADR_W-1:0] hcount,
	output logic rd_stb,
	output logic l_sel,
	output logic overrun
);

	localparam logic [HADR_W-1:0] H_LAST = HADR_W'(H_PIXELS - 1);
	localparam logic [VADR_W-1:0] V_LAST = VADR_W'(V_LINES - 1);
	localparam logic [SIDX_W-1:0] S_LAST = SIDX_W'(N_SPRITES - 1);

	typedef enum logic [1:0] {S_IDLE, S_READ, S_TEST, S_SPAN} fill_state_t;

	fill_state_t state;
	logic [VADR_W-1:0] vline;
	logic [VADR_W-1:0] vline_nxt;
	logic [VADR_W-1:0] fill_line;
	logic [VADR_W-1:0] dy;
	logic [SIDX_W-1:0] sidx;
	sprite_desc_t desc;
	logic line_end;
	logic abort;
	logic hit;
	logic step;

	sprite_ram #(
		.DEPTH(2 ** SIDX_W),
		.payload_t(sprite_desc_t)
	) u_desc (
		.clk(clk),
		.w_stb(desc_we),
		.w_adr(desc_idx),
		.w_dat(desc_wdata),
		.r_adr(sidx),
		.r_dat(desc)
	);

	assign line_end = cend && (hcount == H_LAST);
	assign vline_nxt = (vline == V_LAST) ? '0 : vline + 1'b1;

	// raster position, buffer swap at every line end
	always_ff @(posedge clk or posedge line_start)
	begin
		if (line_start)
		begin
			hcount <= '0;
			vline <= '0;
			fill_line <= '0;
			l_sel <= 1'b0;
		end
		else if (line_end)
		begin
			hcount <= '0;
			vline <= vline_nxt;
			fill_line <= (vline_nxt == V_LAST) ? '0 : vline_nxt + 1'b1;
			l_sel <= ~l_sel;
		end
		else if (cend)
			hcount <= hcount + 1'b1;
	end

	// y test on the descriptor read in the previous cycle
	assign dy = fill_line - desc.y;
	assign hit = (fill_line >= desc.y) && (dy < VADR_W'(desc.height)) &&
		(desc.width != '0) && (desc.x <= H_LAST);

	// done with the current descriptor
	assign step = ((state == S_TEST) && !hit) || ((state == S_SPAN) && span_done);

	always_ff @(posedge clk or posedge line_start)
	begin
		if (line_start)
		begin
			state <= S_IDLE;
			sidx <= '0;
			overrun <= 1'b0;
		end
		else if (line_end)
		begin
			// fill still busy, drop it
			if (state != S_IDLE)
				overrun <= 1'b1;
			sidx <= '0;
			state <= spr_en ? S_READ : S_IDLE;
		end
		else if (step)
		begin
			if (sidx == S_LAST)
				state <= S_IDLE;
			else
			begin
				sidx <= sidx + 1'b1;
				state <= S_READ;
			end
		end
		else if (state == S_READ)
			state <= S_TEST;
		else if (state == S_TEST)
			state <= S_SPAN;
	end

	// zero-width go cancels a span still being drawn
	assign abort = line_end && (state != S_IDLE);
	assign span_go = abort || ((state == S_TEST) && hit);
	assign span_x = desc.x;
	assign span_w = abort ? '0 : desc.width;
	assign span_color = desc.color;

	assign rd_stb = cend;

endmodule

// ==== logic/sprite_ram.sv ====
module sprite_ram
#(
	parameter int DEPTH = 8,
	parameter type payload_t = logic [7:0]
)
(
	input logic clk,
	input logic w_stb,
	input logic [$clog2(DEPTH)-1:0] w_adr,
	input payload_t w_dat,
	input logic [$clog2(DEPTH)-1:0] r_adr,
	output payload_t r_dat
);

	payload_t mem [DEPTH];

	// read returns the old word on a same-address write
	always_ff @(posedge clk)
	begin
		if (w_stb)
			mem[w_adr] <= w_dat;
		r_dat <= mem[r_adr];
	end

endmodule

// ==== logic/sprite_pkg.sv ====
package sprite_pkg;

	import video_pkg::*;

	// descriptor table index
	localparam int SIDX_W = 3;

	// sprite size fields
	localparam int HEIGHT_W = 6;
	localparam int WIDTH_W = 5;

	// one table entry, a solid rectangle
	// height or width of 0 disables the sprite
	typedef struct packed
	{
		logic [HADR_W-1:0] x;
		logic [VADR_W-1:0] y;
		logic [HEIGHT_W-1:0] height;
		logic [WIDTH_W-1:0] width;
		logic [PIX_W-1:0] color;
	} sprite_desc_t;

endpackage

// ==== logic/video_pkg.sv ====
package video_pkg;

	// pixel address within a visible line
	localparam int HADR_W = 9;

	// line number within a frame
	localparam int VADR_W = 9;

	// colour index, palette lookup happens further down the video path
	localparam int PIX_W = 6;

	// one line buffer entry
	// en low means transparent, pixel is then don't care
	typedef struct packed
	{
		logic en;
		logic [PIX_W-1:0] pixel;
	} spx_t;

endpackage
